//--- source/ps2Pkg.sv
// PS/2 line protocol definitions
package ps2Pkg;

    // Frame layout: start, 8 data LSB first, odd parity, stop
    localparam int FRAME_BITS = 11;
    localparam int DATA_BITS  = 8;

    localparam logic START_BIT = 1'b0; // Start bit level
    localparam logic STOP_BIT  = 1'b1; // Stop bit level

    // Scan decoder phases
    // The first four decide on a byte and the last four read one frame
    typedef enum logic [2:0] {
        readMake,   // Start reading a new code
        setFlag,    // Decide on a make byte
        emitKey,    // Pulse the trigger
        clearFlag,  // Decide on the byte after F0h
        readStart,  // Wait out the start bit
        readData,   // Shift in 8 data bits
        readParity, // Skip parity, checked elsewhere
        readStop    // Stop bit, then jump to the return phase
    } decState_t;

endpackage

//--- source/keyPkg.sv
// Keyboard codes and characters
package keyPkg;

    // Set 2 scan codes for the left modifiers
    localparam logic [7:0] LSHIFT = 8'h12;
    localparam logic [7:0] LCTRL  = 8'h14;
    localparam logic [7:0] LALT   = 8'h11;
    localparam logic [7:0] BREAK  = 8'hF0; // Prefix of every break sequence

    // Keys that map to fixed characters
    localparam logic [7:0] SC_SPACE = 8'h29;
    localparam logic [7:0] SC_ENTER = 8'h5A;

    // Modifier word, bit positions
    localparam int MOD_BITS  = 3;
    localparam int MOD_SHIFT = 2;
    localparam int MOD_CTRL  = 1;
    localparam int MOD_ALT   = 0;

    // Characters
    localparam logic [7:0] ASCII_NONE       = 8'h00; // No character for this code
    localparam logic [7:0] ASCII_SPACE      = 8'h20;
    localparam logic [7:0] ASCII_CR         = 8'h0D;
    localparam logic [7:0] ASCII_ZERO       = 8'h30;
    localparam logic [7:0] ASCII_UPPER_BASE = 8'h40; // 'A' minus one
    localparam logic [7:0] ASCII_LOWER_BASE = 8'h60; // 'a' minus one

endpackage

//--- source/ps2LineSync.sv
// PS/2 pin synchronizer
module ps2LineSync (
    input  logic CLOCK,
    input  logic RST_n,
    input  logic PS2_CLK,
    input  logic PS2_DAT,
    output logic fallEdge,
    output logic psData
);

    logic clkSync1;
    logic clkSync2;
    logic clkPrev;  // Last synchronized clock level
    logic datSync1;
    logic datSync2;

    // Both pins idle high, so reset to 1 to avoid a false edge
    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            clkSync1 <= 1'b1;
            clkSync2 <= 1'b1;
            clkPrev  <= 1'b1;
            datSync1 <= 1'b1;
            datSync2 <= 1'b1;
            fallEdge <= 1'b0;
        end else begin
            clkSync1 <= PS2_CLK;  // Metastability stage
            clkSync2 <= clkSync1;
            clkPrev  <= clkSync2;
            datSync1 <= PS2_DAT;
            datSync2 <= datSync1;
            // High to low on the clean clock line
            fallEdge <= clkPrev & ~clkSync2;
        end
    end

    // Data settles long before mid-bit, two flops are enough
    assign psData = datSync2;

endmodule

//--- source/scanDecoder.sv
// Scan code reader and modifier tracker
module scanDecoder (
    input  logic                       CLOCK,
    input  logic                       RST_n,
    input  logic                       fallEdge,
    input  logic                       psData,
    output logic                       keyTrig,
    output logic [7:0]                 keyCode,
    output logic [keyPkg::MOD_BITS-1:0] modifiers
);
    import ps2Pkg::*;
    import keyPkg::*;

    decState_t state;
    decState_t retState;                     // Phase to resume after a frame
    logic [$clog2(DATA_BITS)-1:0] bitCnt;    // Data bit index
    logic [7:0] dataReg;                     // Last received byte
    logic [MOD_BITS-1:0] modReg;             // {shift, ctrl, alt}

    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            state    <= readMake;
            retState <= setFlag;
            bitCnt   <= '0;
            modReg   <= '0;
            keyTrig  <= 1'b0;
        end else begin
            keyTrig <= 1'b0; // Single-cycle pulse
            case (state)
                readMake: begin
                    state    <= readStart;
                    retState <= setFlag;
                end
                setFlag: begin
                    if (dataReg == LSHIFT) begin
                        modReg[MOD_SHIFT] <= 1'b1;
                        state <= readMake;
                    end else if (dataReg == LCTRL) begin
                        modReg[MOD_CTRL] <= 1'b1;
                        state <= readMake;
                    end else if (dataReg == LALT) begin
                        modReg[MOD_ALT] <= 1'b1;
                        state <= readMake;
                    end else if (dataReg == BREAK) begin
                        state    <= readStart; // One more frame holds the released key
                        retState <= clearFlag;
                    end else begin
                        state <= emitKey;      // Ordinary make code
                    end
                end
                emitKey: begin
                    keyTrig <= 1'b1;
                    state   <= readMake;
                end
                clearFlag: begin
                    // Ordinary key releases fall through silently
                    if (dataReg == LSHIFT) modReg[MOD_SHIFT] <= 1'b0;
                    if (dataReg == LCTRL)  modReg[MOD_CTRL]  <= 1'b0;
                    if (dataReg == LALT)   modReg[MOD_ALT]   <= 1'b0;
                    state <= readMake;
                end
                readStart: begin
                    if (fallEdge) begin
                        bitCnt <= '0;
                        state  <= readData;
                    end
                end
                readData: begin
                    if (fallEdge) begin
                        if (bitCnt == 3'(DATA_BITS - 1)) state <= readParity;
                        bitCnt <= bitCnt + 1'b1; // Wraps to 0 after bit 7
                    end
                end
                readParity: begin
                    if (fallEdge) state <= readStop;
                end
                readStop: begin
                    if (fallEdge) state <= retState;
                end
                default: state <= readMake;
            endcase
        end
    end

    // Byte shifter, LSB first
    always_ff @(posedge CLOCK) begin
        if (state == readData && fallEdge) dataReg[bitCnt] <= psData;
    end

    assign keyCode   = dataReg;
    assign modifiers = modReg;

endmodule

//--- source/frameChecker.sv
// PS/2 frame start, parity and stop check
module frameChecker (
    input  logic CLOCK,
    input  logic RST_n,
    input  logic fallEdge,
    input  logic psData,
    output logic frameEnd,
    output logic frameBad
);
    import ps2Pkg::*;

    logic [$clog2(FRAME_BITS)-1:0] bitCnt; // 0 start, 1..8 data, 9 parity, 10 stop
    logic startOk;
    logic parAcc; // XOR of data and parity

    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            bitCnt   <= '0;
            startOk  <= 1'b0;
            parAcc   <= 1'b0;
            frameEnd <= 1'b0;
            frameBad <= 1'b0;
        end else begin
            frameEnd <= 1'b0;
            if (fallEdge) begin
                if (bitCnt == '0) begin
                    startOk <= (psData == START_BIT);
                    parAcc  <= 1'b0;
                end else if (bitCnt <= 4'(DATA_BITS + 1)) begin
                    parAcc <= parAcc ^ psData; // Data bits and parity bit
                end
                if (bitCnt == 4'(FRAME_BITS - 1)) begin
                    bitCnt   <= '0;
                    frameEnd <= 1'b1;
                    // Odd parity leaves parAcc at 1
                    frameBad <= ~startOk | ~parAcc | (psData != STOP_BIT);
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/keyTranslator.sv
// Scan code to ASCII translation
module keyTranslator (
    input  logic                        CLOCK,
    input  logic                        RST_n,
    input  logic                        keyTrig,
    input  logic [7:0]                  keyCode,
    input  logic [keyPkg::MOD_BITS-1:0] modifiers,
    input  logic                        frameEnd,
    input  logic                        frameBad,
    output logic                        keyValid,
    output logic                        keyError,
    output logic [7:0]                  keyAscii,
    output logic [7:0]                  keyOut,
    output logic [keyPkg::MOD_BITS-1:0] modOut
);
    import keyPkg::*;

    logic       errFlag;  // Sticky frame error
    logic [1:0] cleanDly; // Clean frameEnd, delayed to the keyTrig slot

    // Letter position 1..26, 0 if not a letter
    function automatic logic [4:0] letterPos(input logic [7:0] code);
        case (code)
            8'h1C: letterPos = 5'd1;  // a
            8'h32: letterPos = 5'd2;
            8'h21: letterPos = 5'd3;
            8'h23: letterPos = 5'd4;
            8'h24: letterPos = 5'd5;
            8'h2B: letterPos = 5'd6;
            8'h34: letterPos = 5'd7;
            8'h33: letterPos = 5'd8;
            8'h43: letterPos = 5'd9;
            8'h3B: letterPos = 5'd10;
            8'h42: letterPos = 5'd11;
            8'h4B: letterPos = 5'd12;
            8'h3A: letterPos = 5'd13;
            8'h31: letterPos = 5'd14;
            8'h44: letterPos = 5'd15;
            8'h4D: letterPos = 5'd16;
            8'h15: letterPos = 5'd17;
            8'h2D: letterPos = 5'd18;
            8'h1B: letterPos = 5'd19;
            8'h2C: letterPos = 5'd20;
            8'h3C: letterPos = 5'd21;
            8'h2A: letterPos = 5'd22;
            8'h1D: letterPos = 5'd23;
            8'h22: letterPos = 5'd24;
            8'h35: letterPos = 5'd25;
            8'h1A: letterPos = 5'd26; // z
            default: letterPos = 5'd0;
        endcase
    endfunction

    // Digit row, no modifier effect
    function automatic logic [7:0] digitChar(input logic [7:0] code);
        case (code)
            8'h45: digitChar = ASCII_ZERO;
            8'h16: digitChar = ASCII_ZERO + 8'd1;
            8'h1E: digitChar = ASCII_ZERO + 8'd2;
            8'h26: digitChar = ASCII_ZERO + 8'd3;
            8'h25: digitChar = ASCII_ZERO + 8'd4;
            8'h2E: digitChar = ASCII_ZERO + 8'd5;
            8'h36: digitChar = ASCII_ZERO + 8'd6;
            8'h3D: digitChar = ASCII_ZERO + 8'd7;
            8'h3E: digitChar = ASCII_ZERO + 8'd8;
            8'h46: digitChar = ASCII_ZERO + 8'd9;
            default: digitChar = ASCII_NONE;
        endcase
    endfunction

    function automatic logic [7:0] toAscii(input logic [7:0] code,
                                           input logic [MOD_BITS-1:0] mods);
        logic [4:0] pos;
        logic [7:0] chr;
        pos = letterPos(code);
        if (pos != 5'd0) begin
            if (mods[MOD_CTRL]) chr = {3'b000, pos};          // Ctrl beats Shift
            else if (mods[MOD_SHIFT]) chr = ASCII_UPPER_BASE + {3'b000, pos};
            else chr = ASCII_LOWER_BASE + {3'b000, pos};
        end else if (code == SC_SPACE) begin
            chr = ASCII_SPACE;
        end else if (code == SC_ENTER) begin
            chr = ASCII_CR;
        end else begin
            chr = digitChar(code);
        end
        return chr;
    endfunction

    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            errFlag  <= 1'b0;
            cleanDly <= 2'b00;
            keyValid <= 1'b0;
            keyError <= 1'b0;
            modOut   <= '0;
        end else begin
            cleanDly <= {cleanDly[0], frameEnd & ~frameBad};
            keyValid <= keyTrig & ~errFlag;
            keyError <= keyTrig & errFlag;
            modOut   <= modifiers; // Follows every make and break
            // A clean frame with no key two cycles on was a modifier or break
            if (frameEnd && frameBad) errFlag <= 1'b1;
            else if (keyTrig || cleanDly[1]) errFlag <= 1'b0;
        end
    end

    // Character payload, taken with the trigger
    always_ff @(posedge CLOCK) begin
        if (keyTrig) begin
            keyOut   <= keyCode;
            keyAscii <= toAscii(keyCode, modifiers);
        end
    end

endmodule

//--- source/ps2Keyboard.sv
// PS/2 keyboard receiver, top level
module ps2Keyboard (
    input  logic                        CLOCK,
    input  logic                        RST_n,
    input  logic                        PS2_CLK,
    input  logic                        PS2_DAT,
    output logic                        keyValid,
    output logic                        keyError,
    output logic [7:0]                  keyAscii,
    output logic [7:0]                  keyOut,
    output logic [keyPkg::MOD_BITS-1:0] modOut
);
    import keyPkg::*;

    logic                fallEdge;  // One pulse per PS/2 clock fall
    logic                psData;
    logic                keyTrig;
    logic [7:0]          keyCode;
    logic [MOD_BITS-1:0] modifiers;
    logic                frameEnd;
    logic                frameBad;

    ps2LineSync lineSync0 (
        .CLOCK    (CLOCK),
        .RST_n    (RST_n),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .fallEdge (fallEdge),
        .psData   (psData)
    );

    scanDecoder decoder0 (
        .CLOCK     (CLOCK),
        .RST_n     (RST_n),
        .fallEdge  (fallEdge),
        .psData    (psData),
        .keyTrig   (keyTrig),
        .keyCode   (keyCode),
        .modifiers (modifiers)
    );

    // Runs beside the decoder on the same bit stream
    frameChecker checker0 (
        .CLOCK    (CLOCK),
        .RST_n    (RST_n),
        .fallEdge (fallEdge),
        .psData   (psData),
        .frameEnd (frameEnd),
        .frameBad (frameBad)
    );

    keyTranslator translator0 (
        .CLOCK     (CLOCK),
        .RST_n     (RST_n),
        .keyTrig   (keyTrig),
        .keyCode   (keyCode),
        .modifiers (modifiers),
        .frameEnd  (frameEnd),
        .frameBad  (frameBad),
        .keyValid  (keyValid),
        .keyError  (keyError),
        .keyAscii  (keyAscii),
        .keyOut    (keyOut),
        .modOut    (modOut)
    );

endmodule

//--- test/tbClock.sv
// Testbench clock source
module tbClock #(
    parameter int PERIOD = 8
) (
    output logic CLOCK
);

    initial CLOCK = 1'b0;
    always #(PERIOD / 2) CLOCK = ~CLOCK; // Free-running

endmodule

//--- test/ps2Keyboard_sva.sv
// Output strobe assertions
module ps2Keyboard_sva (
    input logic CLOCK,
    input logic RST_n,
    input logic keyValid,
    input logic keyError
);

    int failCount = 0; // Assertion failures so far

    // One outcome per key
    strobeOneHot: assert property (@(posedge CLOCK) disable iff (!RST_n)
        !(keyValid && keyError)) else begin
        failCount++;
        $error("keyValid and keyError high together");
    end

    validPulse: assert property (@(posedge CLOCK) disable iff (!RST_n)
        keyValid |=> !keyValid) else begin
        failCount++;
        $error("keyValid longer than one cycle");
    end

    errorPulse: assert property (@(posedge CLOCK) disable iff (!RST_n)
        keyError |=> !keyError) else begin
        failCount++;
        $error("keyError longer than one cycle");
    end

    // Async reset keeps both strobes low
    quietInReset: assert property (@(posedge CLOCK)
        !RST_n |-> !keyValid && !keyError) else begin
        failCount++;
        $error("Strobe high during reset");
    end

endmodule

bind ps2Keyboard ps2Keyboard_sva sva0 (
    .CLOCK    (CLOCK),
    .RST_n    (RST_n),
    .keyValid (keyValid),
    .keyError (keyError)
);

//--- test/ps2Keyboard_tb.sv
// PS/2 keyboard receiver testbench
module ps2Keyboard_tb;
    import keyPkg::*;

    localparam int NUM_SEQ = 120;
    localparam int BIT_CYC = 16;  // CLOCK cycles per PS/2 bit
    localparam int GAP     = 48;  // Idle cycles after each frame
    localparam int LATENCY = 7;   // Stop bit fall to strobe
    localparam int LIMIT   = NUM_SEQ * 3 * (11 * BIT_CYC + GAP) + 400;

    // Set 2 make codes, a..z then 0..9
    localparam logic [0:25][7:0] LETTERS = {8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
        8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15,
        8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    localparam logic [0:9][7:0] DIGITS = {8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
        8'h36, 8'h3D, 8'h3E, 8'h46};

    typedef struct packed {
        logic       isErr;
        logic [7:0] code;
        logic [7:0] ascii;
        logic [2:0] mods;
    } keyEvent_t;

    logic        CLOCK;
    logic        RST_n;
    logic        PS2_CLK;
    logic        PS2_DAT;
    logic        keyValid;
    logic        keyError;
    logic [7:0]  keyAscii;
    logic [7:0]  keyOut;
    logic [2:0]  modOut;
    int          cycle = 0;
    int          lastStop = 0;      // Counter value just after the last stop fall
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          strobes = 0;
    int          expected = 0;
    logic [31:0] rng = 32'hdbd2;
    logic [2:0]  modelMods = '0;    // {shift, ctrl, alt}
    logic        dirty = 1'b0;      // Bad frame not yet answered
    keyEvent_t   expQ[$];
    keyEvent_t   head;

    tbClock #(.PERIOD(8)) clock0 (.CLOCK(CLOCK));

    ps2Keyboard dut0 (
        .CLOCK    (CLOCK),
        .RST_n    (RST_n),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .keyValid (keyValid),
        .keyError (keyError),
        .keyAscii (keyAscii),
        .keyOut   (keyOut),
        .modOut   (modOut)
    );

    always @(posedge CLOCK) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] pickKey(input int idx);
        if (idx < 26) return LETTERS[idx];
        if (idx < 36) return DIGITS[idx - 26];
        if (idx == 36) return 8'h29; // Space
        if (idx == 37) return 8'h5A; // Enter
        return 8'h76;                // Escape, no character
    endfunction

    // Character rule: Ctrl over Shift on letters, others fixed
    function automatic logic [7:0] expectChar(input logic [7:0] code, input logic [2:0] mods);
        logic [7:0] chr;
        chr = 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (LETTERS[i] == code) begin
                if (mods[MOD_CTRL]) chr = 8'(i + 1);
                else if (mods[MOD_SHIFT]) chr = 8'h41 + 8'(i);
                else chr = 8'h61 + 8'(i);
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (DIGITS[i] == code) chr = 8'h30 + 8'(i);
        end
        if (code == 8'h29) chr = 8'h20;
        if (code == 8'h5A) chr = 8'h0D;
        return chr;
    endfunction

    task automatic sendBit(input logic b, input logic isStop);
        @(posedge CLOCK);
        PS2_DAT <= b;                      // Clock line high here
        repeat (BIT_CYC / 2 - 1) @(posedge CLOCK);
        PS2_CLK <= 1'b0;                   // Mid-bit fall
        if (isStop) lastStop = cycle + 1;
        repeat (BIT_CYC / 2) @(posedge CLOCK);
        PS2_CLK <= 1'b1;
    endtask

    task automatic sendFrame(input logic [7:0] code, input logic corrupt);
        sendBit(1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            sendBit(code[i], 1'b0);        // LSB first
        end
        sendBit(~^code ^ corrupt, 1'b0);   // Odd parity unless corrupted
        sendBit(1'b1, 1'b1);
        repeat (GAP) @(posedge CLOCK);
    endtask

    // Compare each strobe with the oldest expected key
    always @(negedge CLOCK) begin
        if (RST_n === 1'b1 && (keyValid || keyError)) begin
            strobes++;
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Strobe at %0t with no key pending in the model", $time);
            end else begin
                head = expQ.pop_front();
                assert (keyError == head.isErr) else begin
                    valueErrors++;
                    $display("Error at %0t: keyError = %b, expected %b", $time, keyError,
                             head.isErr);
                end
                assert (keyOut == head.code) else begin
                    valueErrors++;
                    $display("Error at %0t: keyOut = %h, expected %h", $time, keyOut, head.code);
                end
                if (!head.isErr) begin
                    assert (keyAscii == head.ascii) else begin
                        valueErrors++;
                        $display("Error at %0t: keyAscii = %h, expected %h", $time, keyAscii,
                                 head.ascii);
                    end
                    assert (modOut == head.mods) else begin
                        valueErrors++;
                        $display("Error at %0t: modOut = %b, expected %b", $time, modOut,
                                 head.mods);
                    end
                end
                assert (cycle - lastStop == LATENCY) else begin
                    otherErrors++;
                    $display("Strobe at %0t came %0d cycles after the stop bit instead of %0d",
                             $time, cycle - lastStop, LATENCY);
                end
            end
        end
    end

    initial begin
        while (cycle < LIMIT)
            @(posedge CLOCK);
        $display("Run stopped after %0d cycles without finishing", LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        keyEvent_t  ev;
        logic [7:0] code;
        logic       isMod;
        logic       isBreak;
        logic       bad;
        RST_n   <= 1'b0;
        PS2_CLK <= 1'b1;  // Idle line
        PS2_DAT <= 1'b1;
        repeat (16) @(posedge CLOCK);
        RST_n <= 1'b1;
        repeat (8) @(posedge CLOCK);
        for (int s = 0; s < NUM_SEQ; s++) begin
            rng = xorshift32(rng);
            isMod   = (rng[1:0] == 2'b00);  // Modifier about 1 in 4
            code    = isMod ? (rng[9:8] == 2'd0 ? LSHIFT : rng[9:8] == 2'd1 ? LCTRL : LALT)
                            : pickKey(int'(rng[31:16]) % 39);
            isBreak = isMod ? rng[4] : (rng[5:4] == 2'b00);
            bad     = (rng[14:12] == 3'b000);
            if (isBreak) begin
                sendFrame(BREAK, bad);
                dirty = bad;
                rng = xorshift32(rng);
                bad = (rng[14:12] == 3'b000);
                sendFrame(code, bad);
                dirty = bad;                // Clean non-key frame drops old error
            end else if (isMod) begin
                sendFrame(code, bad);
                dirty = bad;
            end else begin
                ev = '{isErr: dirty | bad, code: code, ascii: expectChar(code, modelMods),
                       mods: modelMods};
                expQ.push_back(ev);
                expected++;
                sendFrame(code, bad);
                dirty = 1'b0;
            end
            if (isMod) begin
                case (code)
                    LSHIFT: modelMods[MOD_SHIFT] = ~isBreak;
                    LCTRL:  modelMods[MOD_CTRL]  = ~isBreak;
                    default: modelMods[MOD_ALT]  = ~isBreak;
                endcase
            end
            assert (modOut == modelMods) else begin
                valueErrors++;
                $display("Error at %0t: modOut = %b, expected %b", $time, modOut, modelMods);
            end
        end
        repeat (GAP) @(posedge CLOCK);
        assert (strobes == expected && expQ.size() == 0) else begin
            otherErrors++;
            $display("Saw %0d strobes but the model expected %0d", strobes, expected);
        end
        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, dut0.sva0.failCount);
        if (valueErrors + otherErrors + dut0.sva0.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- project.f
source/ps2Pkg.sv
source/keyPkg.sv
source/ps2LineSync.sv
source/scanDecoder.sv
source/frameChecker.sv
source/keyTranslator.sv
source/ps2Keyboard.sv
test/tbClock.sv
test/ps2Keyboard_sva.sv
test/ps2Keyboard_tb.sv

//--- Bender.yml
package:
  name: ps2_keyboard

sources:
  - source/ps2Pkg.sv
  - source/keyPkg.sv
  - source/ps2LineSync.sv
  - source/scanDecoder.sv
  - source/frameChecker.sv
  - source/keyTranslator.sv
  - source/ps2Keyboard.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/ps2Keyboard_sva.sv
      - test/ps2Keyboard_tb.sv
